// File: common/axiLitePkg.sv
// --------------------
// AXI4-Lite widths, response codes,
// front end states
// --------------------
`default_nettype none

package axiLitePkg;

	// 4 channels x 4 registers x 4 bytes
	localparam int addrWidth = 6;
	localparam int dataWidth = 32;

	// no error responses are generated
	localparam logic [1:0] respOkay = 2'b00;

	// front end request sequencing
	typedef enum logic [1:0]
	{
		waitReq,
		issue,
		waitResp
	} frontState_t;

endpackage

`default_nettype wire

// File: common/spiHostPkg.sv
// --------------------
// SPI host register map, control bit
// positions, channel count, engine states
// --------------------
`default_nettype none

package spiHostPkg;

	// number of identical SPI channels
	localparam int channelCount = 4;

	// register index, address bits 3:2
	// channel sits in address bits 5:4
	localparam logic [1:0] regCtrl = 2'd0;
	localparam logic [1:0] regData = 2'd1;
	localparam logic [1:0] regQueue = 2'd2;

	// control register fields
	localparam int ctrlCsBit = 0;
	// start on write, busy on read
	localparam int ctrlStartBit = 1;
	localparam int ctrlBurstBit = 5;
	// 8-bit clock divider
	localparam int ctrlDivLsb = 24;

	// bytes in one queued burst
	localparam int queueBytes = 4;

	// per-channel shift engine
	typedef enum logic [1:0]
	{
		idle,
		shiftByte,
		nextByte
	} engineState_t;

endpackage

`default_nettype wire

// File: common/spiRegIf.sv
// --------------------
// register access between front end,
// one engine and the response merger
// --------------------
`timescale 1ns/1ps
`default_nettype none

interface spiRegIf import axiLitePkg::*; ();

	// request, held by the front end until the next accept
	logic reqValid;
	logic reqWrite;
	logic [1:0] reqReg;
	logic [dataWidth-1:0] reqData;

	// response pulse from the engine
	logic respValid;
	logic [dataWidth-1:0] respData;

	modport front
	(
		output reqValid,
		output reqWrite,
		output reqReg,
		output reqData
	);

	modport engine
	(
		input reqValid,
		input reqWrite,
		input reqReg,
		input reqData,
		output respValid,
		output respData
	);

	// merger also needs the direction of the answered request
	modport merge
	(
		input reqWrite,
		input respValid,
		input respData
	);

endinterface

`default_nettype wire

// File: hdl/axiLiteFront.sv
// --------------------
// AXI4-Lite address and data accept,
// channel decode, one request at a time
// --------------------
`timescale 1ns/1ps
`default_nettype none

module axiLiteFront
	import axiLitePkg::*;
	import spiHostPkg::*;
(
	input logic clock,
	input logic reset,
	input logic [addrWidth-1:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [dataWidth-1:0] wdata,
	input logic wvalid,
	output logic wready,
	input logic [addrWidth-1:0] araddr,
	input logic arvalid,
	output logic arready,
	input logic respTaken,
	spiRegIf.front chan [channelCount]
);

	frontState_t state;

	// latched request, shared by all channels
	logic isWrite;
	logic [1:0] chanSel;
	logic [1:0] regSel;
	logic [dataWidth-1:0] wrData;

	logic portsOpen;
	logic bothWrite;
	logic writeAccept;
	logic readAccept;

	assign portsOpen = (state == waitReq);
	assign bothWrite = awvalid && wvalid;

	// write needs AW and W together, and beats a read
	assign writeAccept = portsOpen && bothWrite;
	assign readAccept = portsOpen && arvalid && !bothWrite;

	// ready drops for a lone AW or W so neither half is taken alone
	assign awready = portsOpen && (wvalid || !awvalid);
	assign wready = portsOpen && (awvalid || !wvalid);
	assign arready = portsOpen && !bothWrite;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= waitReq;
		end
		else
		begin
			case (state)
				waitReq:
				begin
					if (writeAccept || readAccept)
						state <= issue;
				end
				// reqValid is high for exactly this cycle
				issue:
				begin
					state <= waitResp;
				end
				// closed until B or R has been taken
				waitResp:
				begin
					if (respTaken)
						state <= waitReq;
				end
				default:
				begin
					state <= waitReq;
				end
			endcase
		end
	end

	// address fields and write data
	always_ff @(posedge clock)
	begin
		if (writeAccept)
		begin
			isWrite <= 1'b1;
			chanSel <= awaddr[5:4];
			regSel <= awaddr[3:2];
			wrData <= wdata;
		end
		else if (readAccept)
		begin
			isWrite <= 1'b0;
			chanSel <= araddr[5:4];
			regSel <= araddr[3:2];
		end
	end

	// only the addressed channel sees the pulse
	for (genvar g = 0; g < channelCount; g++)
	begin : genReq
		assign chan[g].reqValid = (state == issue) && (chanSel == 2'(g));
		assign chan[g].reqWrite = isWrite;
		assign chan[g].reqReg = regSel;
		assign chan[g].reqData = wrData;
	end

	// a B or R handshake only ever closes the open request
	assert property (@(posedge clock) disable iff (reset)
		respTaken |-> (state == waitResp));

endmodule

`default_nettype wire

// File: spiEngine/spiEngine.sv
// --------------------
// one SPI mode 0 channel with registers,
// divider, shifter and 4-byte queues
// --------------------
`timescale 1ns/1ps
`default_nettype none

module spiEngine
	import spiHostPkg::*;
(
	input logic clock,
	input logic reset,
	spiRegIf.engine bus,
	output logic sclk,
	output logic mosi,
	output logic cs,
	input logic miso
);

	engineState_t state;
	logic busy;
	logic pending;
	logic burst;
	logic [31:0] ctrlReg;

	// half period counter, loads divider + 1
	logic [8:0] halfCnt;
	logic sclkInt;
	logic [2:0] bitCnt;
	logic [1:0] byteCnt;

	logic misoReg;
	logic [7:0] txData;
	logic [7:0] txShift;
	logic [7:0] rxShift;
	logic [7:0] rxByte;
	logic [31:0] sendQ;
	logic [31:0] recvQ;
	logic [31:0] readData;

	logic reqHere;
	logic isQueue;
	logic serve;
	logic ctrlWrite;
	logic startBurst;
	logic startByte;
	logic halfEnd;
	logic fallEdge;

	// a held request stays on the bus until answered
	assign reqHere = bus.reqValid || pending;
	assign isQueue = (bus.reqReg == regQueue);
	// ctrl and data wait for idle, queue never waits
	assign serve = reqHere && (isQueue || !busy);
	assign ctrlWrite = serve && bus.reqWrite && (bus.reqReg == regCtrl);
	// burst wins if both start bits are set
	assign startBurst = ctrlWrite && bus.reqData[ctrlBurstBit];
	assign startByte = ctrlWrite && bus.reqData[ctrlStartBit] && !startBurst;
	assign halfEnd = (halfCnt == 9'd0);
	assign fallEdge = (state == shiftByte) && halfEnd && sclkInt;

	always_comb
	begin
		readData = 32'd0;
		case (bus.reqReg)
			regCtrl:
			begin
				readData = ctrlReg;
				readData[ctrlStartBit] = busy;
			end
			regData:
			begin
				readData[7:0] = rxByte;
			end
			regQueue:
			begin
				readData = recvQ;
			end
			default:
			begin
				readData = 32'd0;
			end
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= idle;
			busy <= 1'b0;
			pending <= 1'b0;
			burst <= 1'b0;
			// CS inactive, divider 0
			ctrlReg <= 32'd1;
			halfCnt <= 9'd0;
			sclkInt <= 1'b0;
			bitCnt <= 3'd0;
			byteCnt <= 2'd0;
			bus.respValid <= 1'b0;
			sclk <= 1'b0;
			mosi <= 1'b1;
			cs <= 1'b1;
		end
		else
		begin
			bus.respValid <= serve;
			pending <= reqHere && !serve;

			// start and burst bits do not stick
			if (ctrlWrite)
			begin
				ctrlReg <= bus.reqData;
				ctrlReg[ctrlStartBit] <= 1'b0;
				ctrlReg[ctrlBurstBit] <= 1'b0;
			end

			case (state)
				idle:
				begin
					sclkInt <= 1'b0;
					bitCnt <= 3'd0;
					byteCnt <= 2'd0;
					if (startByte || startBurst)
					begin
						// new divider comes with the same write
						halfCnt <= {1'b0, bus.reqData[ctrlDivLsb +: 8]} + 9'd1;
						state <= shiftByte;
						busy <= 1'b1;
						burst <= startBurst;
					end
				end
				shiftByte:
				begin
					if (halfEnd)
					begin
						halfCnt <= {1'b0, ctrlReg[ctrlDivLsb +: 8]} + 9'd1;
						sclkInt <= !sclkInt;
						// bit ends on the falling edge
						if (sclkInt)
						begin
							bitCnt <= bitCnt + 3'd1;
							if (bitCnt == 3'd7)
								state <= nextByte;
						end
					end
					else
					begin
						halfCnt <= halfCnt - 9'd1;
					end
				end
				nextByte:
				begin
					// this cycle counts toward the next low phase
					halfCnt <= halfCnt - 9'd1;
					if (burst && (byteCnt != 2'(queueBytes - 1)))
					begin
						byteCnt <= byteCnt + 2'd1;
						state <= shiftByte;
					end
					else
					begin
						state <= idle;
						busy <= 1'b0;
						burst <= 1'b0;
					end
				end
				default:
				begin
					state <= idle;
				end
			endcase

			// pins registered once
			sclk <= sclkInt;
			mosi <= (state == shiftByte) ? txShift[7] : 1'b1;
			cs <= ctrlReg[ctrlCsBit];
		end
	end

	always_ff @(posedge clock)
	begin
		misoReg <= miso;

		if (serve)
			bus.respData <= readData;

		if (serve && bus.reqWrite && (bus.reqReg == regData))
			txData <= bus.reqData[7:0];

		if (startBurst)
			txShift <= sendQ[7:0];
		else if (startByte)
			txShift <= txData;

		// slave data held through the high phase, taken before the fall
		if (fallEdge)
		begin
			txShift <= {txShift[6:0], 1'b0};
			rxShift <= {rxShift[6:0], misoReg};
		end

		// least significant byte goes out and comes back first
		if (state == nextByte)
		begin
			rxByte <= rxShift;
			if (burst)
			begin
				recvQ <= {rxShift, recvQ[31:8]};
				txShift <= sendQ[15:8];
				sendQ <= {8'hFF, sendQ[31:8]};
			end
		end

		if (serve && bus.reqWrite && isQueue)
			sendQ <= bus.reqData;
	end

	// every transfer ends after a falling edge, so SCLK rests low
	assert property (@(posedge clock) disable iff (reset)
		!busy |-> !sclkInt);

	// a held request is the only one outstanding
	assert property (@(posedge clock) disable iff (reset)
		pending |-> !bus.reqValid);

endmodule

`default_nettype wire

// File: hdl/respMerge.sv
// --------------------
// engine response merge, B and R channels
// --------------------
`timescale 1ns/1ps
`default_nettype none

module respMerge
	import axiLitePkg::*;
	import spiHostPkg::*;
(
	input logic clock,
	input logic reset,
	spiRegIf.merge chan [channelCount],
	output logic bvalid,
	input logic bready,
	output logic [1:0] bresp,
	output logic rvalid,
	input logic rready,
	output logic [1:0] rresp,
	output logic [dataWidth-1:0] rdata,
	output logic respTaken
);

	logic [channelCount-1:0] respVec;
	logic [channelCount-1:0] writeVec;
	logic [dataWidth-1:0] dataVec [channelCount];

	logic anyResp;
	logic selWrite;
	logic [dataWidth-1:0] selData;

	for (genvar g = 0; g < channelCount; g++)
	begin : genTap
		assign respVec[g] = chan[g].respValid;
		assign writeVec[g] = chan[g].reqWrite;
		assign dataVec[g] = chan[g].respData;
	end

	// at most one pulse, so an OR picks it
	always_comb
	begin
		selData = '0;
		for (int i = 0; i < channelCount; i++)
		begin
			if (respVec[i])
				selData = selData | dataVec[i];
		end
	end

	assign anyResp = |respVec;
	assign selWrite = |(respVec & writeVec);

	assign bresp = respOkay;
	assign rresp = respOkay;
	assign respTaken = (bvalid && bready) || (rvalid && rready);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			bvalid <= 1'b0;
			rvalid <= 1'b0;
		end
		else
		begin
			if (bvalid && bready)
				bvalid <= 1'b0;
			if (rvalid && rready)
				rvalid <= 1'b0;
			if (anyResp && selWrite)
				bvalid <= 1'b1;
			if (anyResp && !selWrite)
				rvalid <= 1'b1;
		end
	end

	// held until the R handshake
	always_ff @(posedge clock)
	begin
		if (anyResp && !selWrite)
			rdata <= selData;
	end

	assert property (@(posedge clock) disable iff (reset)
		$onehot0(respVec));

endmodule

`default_nettype wire

// File: hdl/spiHostTop.sv
// --------------------
// SPI host top, AXI4-Lite and SPI pins
// --------------------
`timescale 1ns/1ps
`default_nettype none

module spiHostTop
	import axiLitePkg::*;
	import spiHostPkg::*;
(
	input logic clock,
	input logic reset,
	input logic [addrWidth-1:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [dataWidth-1:0] wdata,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input logic [addrWidth-1:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [dataWidth-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready,
	output logic [channelCount-1:0] sclk,
	output logic [channelCount-1:0] mosi,
	output logic [channelCount-1:0] cs,
	input logic [channelCount-1:0] miso
);

	logic respTaken;

	// one register link per channel
	spiRegIf regIf [channelCount] ();

	axiLiteFront front
	(
		.clock(clock),
		.reset(reset),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wvalid(wvalid),
		.wready(wready),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.respTaken(respTaken),
		.chan(regIf)
	);

	for (genvar g = 0; g < channelCount; g++)
	begin : genEngine
		spiEngine engine
		(
			.clock(clock),
			.reset(reset),
			.bus(regIf[g]),
			.sclk(sclk[g]),
			.mosi(mosi[g]),
			.cs(cs[g]),
			.miso(miso[g])
		);
	end

	respMerge merge
	(
		.clock(clock),
		.reset(reset),
		.chan(regIf),
		.bvalid(bvalid),
		.bready(bready),
		.bresp(bresp),
		.rvalid(rvalid),
		.rready(rready),
		.rresp(rresp),
		.rdata(rdata),
		.respTaken(respTaken)
	);

endmodule

`default_nettype wire

// File: test/tbClockGen.sv
// --------------------
// testbench clock, 4 ns period, and reset
// --------------------
`timescale 1ns/1ps
`default_nettype none

module tbClockGen
(
	output logic clock,
	output logic reset
);

	initial
	begin
		clock = 1'b0;
		forever #2 clock = !clock;
	end

	// released just after the 16th rising edge
	initial
	begin
		reset = 1'b1;
		repeat (16) @(posedge clock);
		#1;
		reset = 1'b0;
	end

endmodule

`default_nettype wire

// File: test/spiHostTb.sv
// --------------------
// SPI host testbench, AXI master tasks,
// inverting SPI slaves, register model
// --------------------
`timescale 1ns/1ps
`default_nettype none

module spiHostTb
	import axiLitePkg::*;
	import spiHostPkg::*;
();

	// longest wait allowed in any loop, in cycles
	localparam int waitLimit = 50000;

	logic clock;
	logic reset;
	logic [addrWidth-1:0] awaddr;
	logic awvalid;
	logic awready;
	logic [dataWidth-1:0] wdata;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [addrWidth-1:0] araddr;
	logic arvalid;
	logic arready;
	logic [dataWidth-1:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;
	logic [channelCount-1:0] sclk;
	logic [channelCount-1:0] mosi;
	logic [channelCount-1:0] cs;
	logic [channelCount-1:0] miso;

	int seed = 92;
	int checkCount = 0;
	int errorCount = 0;
	bit timedOut = 1'b0;
	int cycleNow = 0;
	int overlapCycles = 0;

	// SCLK observation per channel
	logic [channelCount-1:0] sclkPrev;
	int riseCount [channelCount];
	int highLen [channelCount];
	int lastHigh [channelCount];

	// register model per channel
	logic [31:0] ctrlModel [channelCount];
	logic [7:0] divModel [channelCount];
	logic [7:0] txModel [channelCount];
	logic [7:0] rxModel [channelCount];
	logic [31:0] sendModel [channelCount];
	logic [31:0] queueModel [channelCount];
	bit mayBusy [channelCount];
	bit rxValid [channelCount];
	bit queueValid [channelCount];

	// control write in flight, its divider is live once B is raised
	int divWriteCh = -1;
	logic [7:0] divWriteVal;

	tbClockGen clockGen
	(
		.clock(clock),
		.reset(reset)
	);

	spiHostTop dut
	(
		.clock(clock),
		.reset(reset),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready),
		.sclk(sclk),
		.mosi(mosi),
		.cs(cs),
		.miso(miso)
	);

	// slave returns the complement of every bit it sees
	assign miso = ~mosi;

	task automatic expectTrue(input bit cond, input string what);
		checkCount++;
		assert (cond)
		else
		begin
			errorCount++;
			$display("Fail at %0t ns: %s", $time, what);
		end
	endtask

	// pins change on the rising edge, so look at them on the falling one
	always @(negedge clock)
	begin
		cycleNow++;
		if (!reset)
		begin
			// the engine takes a new divider before it answers
			if ((divWriteCh >= 0) && bvalid)
				divModel[divWriteCh] = divWriteVal;
			if ($countones(sclk) > 1)
				overlapCycles++;
			for (int c = 0; c < channelCount; c++)
			begin
				if (sclk[c] && !sclkPrev[c])
				begin
					riseCount[c]++;
					highLen[c] = 1;
				end
				else if (sclk[c])
				begin
					highLen[c]++;
				end
				else if (sclkPrev[c])
				begin
					lastHigh[c] = highLen[c];
					expectTrue(highLen[c] == int'(divModel[c]) + 2,
						$sformatf("channel %0d SCLK high for %0d cycles, divider %0d",
						c, highLen[c], divModel[c]));
				end
			end
			sclkPrev = sclk;
		end
	end

	// called at the drive point, returns at the drive point
	task automatic writeReg(input int ch, input logic [1:0] regIdx, input logic [31:0] value);
		int count;
		if (timedOut)
			return;
		awaddr = {2'(ch), regIdx, 2'b00};
		wdata = value;
		awvalid = 1'b1;
		wvalid = 1'b1;
		count = 0;
		@(negedge clock);
		while (!(awready && wready) && (count < waitLimit))
		begin
			count++;
			@(negedge clock);
		end
		@(posedge clock);
		#1;
		awvalid = 1'b0;
		wvalid = 1'b0;
		if (count >= waitLimit)
		begin
			$display("Timeout: the write address and data were never accepted");
			timedOut = 1'b1;
			return;
		end
		// random BREADY stalls
		count = 0;
		bready = $random(seed);
		@(negedge clock);
		while (!(bvalid && bready) && (count < waitLimit))
		begin
			count++;
			@(posedge clock);
			#1;
			bready = $random(seed);
			@(negedge clock);
		end
		if (!(bvalid && bready))
		begin
			$display("Timeout: no write response arrived");
			timedOut = 1'b1;
			return;
		end
		expectTrue(bresp == respOkay, "write response is not OKAY");
		@(posedge clock);
		#1;
		bready = 1'b0;
	endtask

	task automatic readReg(input int ch, input logic [1:0] regIdx, output logic [31:0] value);
		int count;
		value = 32'd0;
		if (timedOut)
			return;
		araddr = {2'(ch), regIdx, 2'b00};
		arvalid = 1'b1;
		count = 0;
		@(negedge clock);
		while (!arready && (count < waitLimit))
		begin
			count++;
			@(negedge clock);
		end
		@(posedge clock);
		#1;
		arvalid = 1'b0;
		if (count >= waitLimit)
		begin
			$display("Timeout: the read address was never accepted");
			timedOut = 1'b1;
			return;
		end
		count = 0;
		rready = $random(seed);
		@(negedge clock);
		while (!(rvalid && rready) && (count < waitLimit))
		begin
			count++;
			@(posedge clock);
			#1;
			rready = $random(seed);
			@(negedge clock);
		end
		if (!(rvalid && rready))
		begin
			$display("Timeout: no read data arrived");
			timedOut = 1'b1;
			return;
		end
		value = rdata;
		expectTrue(rresp == respOkay, "read response is not OKAY");
		@(posedge clock);
		#1;
		rready = 1'b0;
	endtask

	function automatic logic [31:0] controlWord(input logic csLevel, input logic [7:0] div,
		input logic startByte, input logic startBurst);
		logic [31:0] v;
		v = $random(seed);
		v[ctrlDivLsb +: 8] = div;
		v[ctrlCsBit] = csLevel;
		v[ctrlStartBit] = startByte;
		v[ctrlBurstBit] = startBurst;
		return v;
	endfunction

	// write control and predict what the channel does with it
	task automatic setControl(input int ch, input logic [31:0] value);
		divWriteCh = ch;
		divWriteVal = value[ctrlDivLsb +: 8];
		writeReg(ch, regCtrl, value);
		divWriteCh = -1;
		ctrlModel[ch] = value;
		ctrlModel[ch][ctrlStartBit] = 1'b0;
		ctrlModel[ch][ctrlBurstBit] = 1'b0;
		divModel[ch] = value[ctrlDivLsb +: 8];
		if (value[ctrlBurstBit])
		begin
			queueModel[ch] = ~sendModel[ch];
			rxModel[ch] = ~sendModel[ch][31:24];
			queueValid[ch] = 1'b1;
			rxValid[ch] = 1'b1;
			mayBusy[ch] = 1'b1;
		end
		else if (value[ctrlStartBit])
		begin
			rxModel[ch] = ~txModel[ch];
			rxValid[ch] = 1'b1;
			mayBusy[ch] = 1'b1;
		end
	endtask

	// a control read is answered only once the channel is idle
	task automatic checkControl(input int ch);
		logic [31:0] got;
		readReg(ch, regCtrl, got);
		expectTrue(got == ctrlModel[ch], $sformatf("channel %0d control read %h, expected %h",
			ch, got, ctrlModel[ch]));
		mayBusy[ch] = 1'b0;
	endtask

	task automatic checkData(input int ch);
		logic [31:0] got;
		readReg(ch, regData, got);
		expectTrue(got == {24'd0, rxModel[ch]}, $sformatf("channel %0d data read %h, expected %h",
			ch, got, rxModel[ch]));
		mayBusy[ch] = 1'b0;
	endtask

	// queue reads never wait, so the burst must be over first
	task automatic checkQueue(input int ch);
		logic [31:0] got;
		if (mayBusy[ch])
			checkControl(ch);
		readReg(ch, regQueue, got);
		expectTrue(got == queueModel[ch], $sformatf("channel %0d queue read %h, expected %h",
			ch, got, queueModel[ch]));
	endtask

	task automatic sendByte(input int ch, input logic [7:0] value, input logic [31:0] ctrl);
		writeReg(ch, regData, {24'd0, value});
		txModel[ch] = value;
		setControl(ch, ctrl);
	endtask

	task automatic sendBurst(input int ch, input logic [31:0] word, input logic [31:0] ctrl);
		if (mayBusy[ch])
			checkControl(ch);
		writeReg(ch, regQueue, word);
		sendModel[ch] = word;
		setControl(ch, ctrl);
	endtask

	task automatic reportTest(input int num, input string name, input int errBefore);
		$display("test %0d %s: %0d errors", num, name, errorCount - errBefore);
	endtask

	initial
	begin : mainSeq
		int count;
		int ch;
		int op;
		int base;
		int startCycle;
		int errBase;
		logic [7:0] b;
		logic [7:0] d;
		logic [31:0] v;
		logic [channelCount-1:0] csExp;

		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		sclkPrev = '0;
		for (int c = 0; c < channelCount; c++)
		begin
			riseCount[c] = 0;
			highLen[c] = 0;
			lastHigh[c] = 0;
			// CS high, divider 0 out of reset
			ctrlModel[c] = 32'd1;
			divModel[c] = 8'd0;
			mayBusy[c] = 1'b0;
			rxValid[c] = 1'b0;
			queueValid[c] = 1'b0;
		end

		count = 0;
		@(posedge clock);
		while (reset && (count < waitLimit))
		begin
			count++;
			@(posedge clock);
		end
		if (reset)
		begin
			$display("Timeout: reset was never released");
			timedOut = 1'b1;
		end
		#1;

		// 1: idle pins and control reset value
		errBase = errorCount;
		for (int k = 0; k < 20; k++)
		begin
			@(negedge clock);
			expectTrue((sclk == '0) && (cs == '1) && (mosi == '1),
				"SCLK low, MOSI high and CS high after reset");
		end
		@(posedge clock);
		#1;
		for (int c = 0; c < channelCount; c++)
			checkControl(c);
		reportTest(1, "reset state", errBase);

		// 2: one byte, full divider range
		errBase = errorCount;
		ch = $unsigned($random(seed)) % channelCount;
		b = $random(seed);
		d = $random(seed);
		base = riseCount[ch];
		sendByte(ch, b, controlWord(1'b0, d, 1'b1, 1'b0));
		checkControl(ch);
		checkData(ch);
		expectTrue(riseCount[ch] - base == 8, "single byte did not give 8 SCLK edges");
		expectTrue(lastHigh[ch] == int'(d) + 2, "SCLK half period differs from divider + 2");
		reportTest(2, "single byte", errBase);

		// 3: four byte burst
		errBase = errorCount;
		ch = $unsigned($random(seed)) % channelCount;
		v = $random(seed);
		d = $random(seed) & 8'h0F;
		base = riseCount[ch];
		sendBurst(ch, v, controlWord(1'b0, d, 1'b0, 1'b1));
		checkControl(ch);
		checkQueue(ch);
		checkData(ch);
		expectTrue(riseCount[ch] - base == 32, "burst did not give 32 SCLK edges");
		reportTest(3, "burst", errBase);

		// 4: control write held off by a running byte
		errBase = errorCount;
		ch = $unsigned($random(seed)) % channelCount;
		b = $random(seed);
		d = 8'd6 + ($random(seed) & 8'h07);
		base = riseCount[ch];
		sendByte(ch, b, controlWord(1'b0, d, 1'b1, 1'b0));
		v = controlWord($random(seed), $random(seed) & 8'h0F, 1'b0, 1'b0);
		startCycle = cycleNow;
		setControl(ch, v);
		expectTrue(riseCount[ch] - base == 8, "write response came before the byte finished");
		expectTrue(cycleNow - startCycle >= 12 * (int'(d) + 2), "write response came too early");
		checkControl(ch);
		checkData(ch);
		reportTest(4, "held control write", errBase);

		// 5: random mix over all channels
		errBase = errorCount;
		overlapCycles = 0;
		for (int c = 0; c < channelCount; c++)
			sendByte(c, $random(seed), controlWord($random(seed), $random(seed) & 8'h0F, 1'b1, 1'b0));
		for (int k = 0; k < 60; k++)
		begin
			ch = $unsigned($random(seed)) % channelCount;
			op = $unsigned($random(seed)) % 6;
			d = $random(seed) & 8'h0F;
			case (op)
				0:
					sendByte(ch, $random(seed), controlWord($random(seed), d, 1'b1, 1'b0));
				1:
					sendBurst(ch, $random(seed), controlWord($random(seed), d, 1'b0, 1'b1));
				2:
				begin
					if (rxValid[ch])
						checkData(ch);
					else
						checkControl(ch);
				end
				3:
					checkControl(ch);
				4:
				begin
					if (queueValid[ch])
						checkQueue(ch);
					else
						checkControl(ch);
				end
				default:
					setControl(ch, controlWord($random(seed), d, 1'b0, 1'b0));
			endcase
		end
		for (int c = 0; c < channelCount; c++)
			checkControl(c);
		expectTrue(overlapCycles > 0, "no two channels were ever shifting together");
		reportTest(5, "random channel mix", errBase);

		// 6: CS level per channel
		errBase = errorCount;
		for (int r = 0; r < 2; r++)
		begin
			for (int c = 0; c < channelCount; c++)
			begin
				v = controlWord($random(seed), $random(seed) & 8'h0F, 1'b0, 1'b0);
				csExp[c] = v[ctrlCsBit];
				setControl(c, v);
				expectTrue(cs[c] == csExp[c], $sformatf("channel %0d CS does not follow bit 0", c));
			end
			repeat (3) @(negedge clock);
			expectTrue(cs == csExp, "CS pins differ from control bit 0");
			@(posedge clock);
			#1;
		end
		reportTest(6, "chip select", errBase);

		$display("checks %0d, errors %0d", checkCount, errorCount);
		if ((errorCount == 0) && !timedOut)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
common/axiLitePkg.sv
common/spiHostPkg.sv
common/spiRegIf.sv
hdl/axiLiteFront.sv
spiEngine/spiEngine.sv
hdl/respMerge.sv
hdl/spiHostTop.sv
test/tbClockGen.sv
test/spiHostTb.sv
